// File: verilog/divPkg.sv
`default_nettype none

package divPkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------

	localparam int MantW = 24;        // Mantissa with hidden one.
	localparam int RemW = MantW + 1;  // Partial remainder, one sign bit on top.
	localparam int ExpW = 9;
	localparam int ExpResW = ExpW + 1;
	localparam int PrecW = 5;
	localparam int CntW = 3;

	// Radix 16, one quotient digit per clock.
	localparam int BitsPerIter = 4;

	// ----------------------------------------
	// Precision control and bias
	// ----------------------------------------

	localparam logic [PrecW-1:0] PrecMin = 5'd8;
	localparam logic [PrecW-1:0] PrecMax = 5'd23;  // Also the fallback for bad values.

	// Counter value that closes the 8..11 precision group.
	localparam logic [CntW-1:0] MinLastCnt = 3'd2;

	// Added to num + ~den, which nets the +127 bias.
	localparam logic [ExpResW-1:0] ExpBiasOne = 10'd128;

	// ----------------------------------------
	// Controller states
	// ----------------------------------------

	typedef enum logic [1:0] {
		Idle    = 2'd0,
		Iterate = 2'd1,
		Finish  = 2'd2
	} divState_t;

endpackage

`default_nettype wire

// File: verilog/divFsm.sv
`timescale 1ns/1ps
`default_nettype none

module divFsm (
	input  wire               Clk_CI,
	input  wire               Rst_RBI,
	input  wire               Start_SI,
	input  wire               LastIter_S,
	output logic              IterEn_S,
	output logic              FirstIter_S,
	output divPkg::divState_t State_S,
	output logic              Ready_SO,
	output logic              Done_SO
);

	divPkg::divState_t stateQ;
	divPkg::divState_t stateNext;
	logic              accept;
	logic              lastStep;
	logic              startDly;

	// A new start is only taken while no division is running.
	assign accept = Start_SI & ((stateQ == divPkg::Idle) | (stateQ == divPkg::Finish));
	assign lastStep = (stateQ == divPkg::Iterate) & LastIter_S;

	always_comb begin
		stateNext = stateQ;
		case (stateQ)
			divPkg::Idle: if (accept) stateNext = divPkg::Iterate;
			divPkg::Iterate: if (lastStep) stateNext = divPkg::Finish;
			divPkg::Finish: stateNext = accept ? divPkg::Iterate : divPkg::Idle;
			default: stateNext = divPkg::Idle;
		endcase
	end

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			stateQ   <= divPkg::Idle;
			startDly <= 1'b0;
			Ready_SO <= 1'b1;
			Done_SO  <= 1'b0;
		end else begin
			stateQ   <= stateNext;
			startDly <= accept;   // Marks the first iterate cycle.
			Done_SO  <= lastStep;
			if (accept)
				Ready_SO <= 1'b0;
			else if (lastStep)
				Ready_SO <= 1'b1;
		end
	end

	assign IterEn_S = (stateQ == divPkg::Iterate);
	assign FirstIter_S = startDly;
	assign State_S = stateQ;

endmodule

`default_nettype wire

// File: verilog/divIterCounter.sv
`timescale 1ns/1ps
`default_nettype none

module divIterCounter (
	input  wire                       Clk_CI,
	input  wire                       Rst_RBI,
	input  wire                       Start_SI,
	input  wire                       Ready_SO,
	input  wire [divPkg::PrecW-1:0]   Precision_SI,
	input  wire                       IterEn_S,
	output logic [divPkg::PrecW-1:0]  PrecisionQ_S,
	output logic                      LastIter_S
);

	logic [divPkg::PrecW-1:0] precClamp;
	logic [divPkg::PrecW-1:0] precOffset;
	logic [divPkg::CntW-1:0]  iterCnt;
	logic [divPkg::CntW-1:0]  lastCnt;

	assign precClamp = ((Precision_SI < divPkg::PrecMin) || (Precision_SI > divPkg::PrecMax)) ?
		divPkg::PrecMax : Precision_SI;

	// Group of four precisions per extra iteration.
	assign precOffset = PrecisionQ_S - divPkg::PrecMin;
	assign lastCnt = divPkg::MinLastCnt + {1'b0, precOffset[3:2]};

	assign LastIter_S = IterEn_S & (iterCnt == lastCnt);

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			PrecisionQ_S <= divPkg::PrecMax;
			iterCnt      <= '0;
		end else begin
			if (Start_SI & Ready_SO)
				PrecisionQ_S <= precClamp;  // Held for the whole division.
			if (LastIter_S)
				iterCnt <= '0;
			else if (IterEn_S)
				iterCnt <= iterCnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/divRemainderPath.sv
`timescale 1ns/1ps
`default_nettype none

module divRemainderPath (
	input  wire                       Clk_CI,
	input  wire                       Rst_RBI,
	input  wire                       IterEn_S,
	input  wire                       FirstIter_S,
	input  wire [divPkg::MantW-1:0]   NumMant_DI,
	input  wire [divPkg::MantW-1:0]   DenMant_DI,
	output logic [divPkg::MantW-1:0]  Quotient_D,
	output logic                      NextQBit_D
);

	logic [divPkg::RemW-1:0] remainderQ;
	logic [divPkg::RemW-1:0] denExt;

	// One entry per add/subtract cell.
	wire [divPkg::RemW-1:0]        cellA [divPkg::BitsPerIter];
	wire [divPkg::RemW-1:0]        cellSum [divPkg::BitsPerIter];
	wire [divPkg::BitsPerIter-1:0] cellSub;
	wire [divPkg::BitsPerIter-1:0] qBits;   // First cell in the MSB.

	assign denExt = {1'b0, DenMant_DI};

	// ----------------------------------------
	// Non-restoring cells
	// ----------------------------------------

	for (genvar i = 0; i < divPkg::BitsPerIter; i++) begin : genCell
		wire [divPkg::RemW-1:0] cellB;

		if (i == 0) begin : genHead
			// The first digit of a division always starts with a subtraction.
			assign cellA[i] = FirstIter_S ? {1'b0, NumMant_DI} :
				{remainderQ[divPkg::RemW-2:0], 1'b0};
			assign cellSub[i] = FirstIter_S | Quotient_D[0];
		end else begin : genChain
			assign cellA[i] = {cellSum[i-1][divPkg::RemW-2:0], 1'b0};
			assign cellSub[i] = qBits[divPkg::BitsPerIter-i];
		end

		// Subtract is a + ~d + 1, the carry in supplies the one.
		assign cellB = cellSub[i] ? ~denExt : denExt;
		assign {qBits[divPkg::BitsPerIter-1-i], cellSum[i]} =
			{1'b0, cellA[i]} + {1'b0, cellB} + {{divPkg::RemW{1'b0}}, cellSub[i]};
	end

	// ----------------------------------------
	// Remainder and quotient registers
	// ----------------------------------------

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			remainderQ <= '0;
			Quotient_D <= '0;
		end else if (IterEn_S) begin
			remainderQ <= cellSum[divPkg::BitsPerIter-1];
			Quotient_D <= {Quotient_D[divPkg::MantW-divPkg::BitsPerIter-1:0], qBits};
		end
	end

	// Outside the first iteration the head cell works on the stored remainder,
	// so after the last iteration its carry is the next quotient bit.
	assign NextQBit_D = qBits[divPkg::BitsPerIter-1];

endmodule

`default_nettype wire

// File: verilog/divResultAssembly.sv
`timescale 1ns/1ps
`default_nettype none

module divResultAssembly (
	input  wire                          Clk_CI,
	input  wire                          Rst_RBI,
	input  wire                          FirstIter_S,
	input  wire divPkg::divState_t       State_S,
	input  wire [divPkg::PrecW-1:0]      PrecisionQ_S,
	input  wire [divPkg::MantW-1:0]      Quotient_D,
	input  wire                          NextQBit_D,
	input  wire signed [divPkg::ExpW-1:0] NumExp_DI,
	input  wire signed [divPkg::ExpW-1:0] DenExp_DI,
	output logic [divPkg::MantW-1:0]     MantResult_DO,
	output logic [divPkg::ExpResW-1:0]   ExpResult_DO
);

	logic [divPkg::PrecW-1:0]   alignShift;
	logic [1:0]                 lowBits;
	logic [divPkg::MantW-1:0]   truncMant;
	logic                       roundBit;
	logic                       roundEn;
	logic [divPkg::MantW:0]     roundVec;
	logic [divPkg::MantW:0]     corrMant;
	logic [divPkg::ExpResW-1:0] numExpExt;
	logic [divPkg::ExpResW-1:0] denExpInv;

	// ----------------------------------------
	// Mantissa alignment
	// ----------------------------------------

	// Zero fill below the P+1 result bits.
	assign alignShift = divPkg::PrecMax - PrecisionQ_S;

	// Each group computes 4 bits per iteration, so the result LSB sits
	// 3 - P[1:0] bits above the quotient LSB.
	assign lowBits = ~PrecisionQ_S[1:0];
	assign truncMant = (Quotient_D >> lowBits) << alignShift;

	always_comb begin
		case (PrecisionQ_S[1:0])
			2'd0: roundBit = Quotient_D[2];
			2'd1: roundBit = Quotient_D[1];
			2'd2: roundBit = Quotient_D[0];
			default: roundBit = NextQBit_D;  // All computed bits are in use.
		endcase
	end

	// ----------------------------------------
	// Last bit correction
	// ----------------------------------------

	assign roundEn = roundBit & (State_S != divPkg::Idle);
	assign roundVec = {{divPkg::MantW{1'b0}}, roundEn} << alignShift;
	assign corrMant = {1'b0, truncMant} + roundVec;

	// Rounding up must not carry out of the mantissa.
	assign MantResult_DO = corrMant[divPkg::MantW] ? truncMant : corrMant[divPkg::MantW-1:0];

	// ----------------------------------------
	// Prenormalized exponent
	// ----------------------------------------

	assign numExpExt = {NumExp_DI[divPkg::ExpW-1], NumExp_DI};
	assign denExpInv = ~{DenExp_DI[divPkg::ExpW-1], DenExp_DI};  // Equals -den - 1.

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI)
			ExpResult_DO <= '0;
		else if (FirstIter_S)
			ExpResult_DO <= numExpExt + denExpInv + divPkg::ExpBiasOne;
	end

endmodule

`default_nettype wire

// File: verilog/divTop.sv
`timescale 1ns/1ps
`default_nettype none

module divTop (
	input  wire                           Clk_CI,
	input  wire                           Rst_RBI,
	input  wire                           Start_SI,
	input  wire [divPkg::PrecW-1:0]       Precision_SI,
	input  wire [divPkg::MantW-1:0]       NumMant_DI,
	input  wire [divPkg::MantW-1:0]       DenMant_DI,
	input  wire signed [divPkg::ExpW-1:0] NumExp_DI,
	input  wire signed [divPkg::ExpW-1:0] DenExp_DI,
	output wire                           Ready_SO,
	output wire                           Done_SO,
	output wire [divPkg::MantW-1:0]       MantResult_DO,
	output wire [divPkg::ExpResW-1:0]     ExpResult_DO
);

	wire                     IterEn_S;
	wire                     FirstIter_S;
	wire                     LastIter_S;
	wire divPkg::divState_t  State_S;
	wire [divPkg::PrecW-1:0] PrecisionQ_S;
	wire [divPkg::MantW-1:0] Quotient_D;
	wire                     NextQBit_D;

	divFsm fsm0 (
		.Clk_CI      (Clk_CI),
		.Rst_RBI     (Rst_RBI),
		.Start_SI    (Start_SI),
		.LastIter_S  (LastIter_S),
		.IterEn_S    (IterEn_S),
		.FirstIter_S (FirstIter_S),
		.State_S     (State_S),
		.Ready_SO    (Ready_SO),
		.Done_SO     (Done_SO)
	);

	divIterCounter cnt0 (
		.Clk_CI       (Clk_CI),
		.Rst_RBI      (Rst_RBI),
		.Start_SI     (Start_SI),
		.Ready_SO     (Ready_SO),
		.Precision_SI (Precision_SI),
		.IterEn_S     (IterEn_S),
		.PrecisionQ_S (PrecisionQ_S),
		.LastIter_S   (LastIter_S)
	);

	divRemainderPath rem0 (
		.Clk_CI      (Clk_CI),
		.Rst_RBI     (Rst_RBI),
		.IterEn_S    (IterEn_S),
		.FirstIter_S (FirstIter_S),
		.NumMant_DI  (NumMant_DI),
		.DenMant_DI  (DenMant_DI),
		.Quotient_D  (Quotient_D),
		.NextQBit_D  (NextQBit_D)
	);

	divResultAssembly res0 (
		.Clk_CI        (Clk_CI),
		.Rst_RBI       (Rst_RBI),
		.FirstIter_S   (FirstIter_S),
		.State_S       (State_S),
		.PrecisionQ_S  (PrecisionQ_S),
		.Quotient_D    (Quotient_D),
		.NextQBit_D    (NextQBit_D),
		.NumExp_DI     (NumExp_DI),
		.DenExp_DI     (DenExp_DI),
		.MantResult_DO (MantResult_DO),
		.ExpResult_DO  (ExpResult_DO)
	);

endmodule

`default_nettype wire

// File: tests/divTb.sv
`timescale 1ns/1ps
`default_nettype none

module divTb;

	localparam int ClkPeriod = 10;
	localparam int NumRand = 200;
	localparam int NumPerPrec = 4;
	localparam int NumExpRand = 40;
	localparam int NumIgnore = 8;
	localparam int NumTests = 2 + NumRand + 20 * NumPerPrec + 4 + NumExpRand + NumIgnore;
	localparam int WatchdogCycles = NumTests * 12 + 4 + 4;

	logic                               Clk_CI = 1'b0;
	logic                               Rst_RBI;
	logic                               Start_SI;
	logic [divPkg::PrecW-1:0]           Precision_SI;
	logic [divPkg::MantW-1:0]           NumMant_DI;
	logic [divPkg::MantW-1:0]           DenMant_DI;
	logic signed [divPkg::ExpW-1:0]     NumExp_DI;
	logic signed [divPkg::ExpW-1:0]     DenExp_DI;
	wire                                Ready_SO;
	wire                                Done_SO;
	wire [divPkg::MantW-1:0]            MantResult_DO;
	wire [divPkg::ExpResW-1:0]          ExpResult_DO;

	logic [divPkg::MantW-1:0]   expMantQ [$];
	logic [divPkg::ExpResW-1:0] expExpQ [$];
	int                         expLatQ [$];
	int                         issued = 0;
	int                         checked = 0;
	int                         cycleCnt = 0;
	int                         startEdge = 0;
	bit                         busy = 1'b0;
	bit                         doneLast = 1'b0;
	int                         outPrec [4] = '{0, 7, 24, 31};

	divTop dut0 (
		.Clk_CI        (Clk_CI),
		.Rst_RBI       (Rst_RBI),
		.Start_SI      (Start_SI),
		.Precision_SI  (Precision_SI),
		.NumMant_DI    (NumMant_DI),
		.DenMant_DI    (DenMant_DI),
		.NumExp_DI     (NumExp_DI),
		.DenExp_DI     (DenExp_DI),
		.Ready_SO      (Ready_SO),
		.Done_SO       (Done_SO),
		.MantResult_DO (MantResult_DO),
		.ExpResult_DO  (ExpResult_DO)
	);

	always #(ClkPeriod / 2) Clk_CI = ~Clk_CI;

	always @(posedge Clk_CI) cycleCnt = cycleCnt + 1;  // Edge index, read at negedge.

	// ----------------------------------------
	// Reference model and checks
	// ----------------------------------------

	function automatic int clampPrec(input logic [4:0] p);
		if (p < 8 || p > 23)
			return 23;
		return p;
	endfunction

	// Returns {exponent, mantissa}.
	function automatic logic [33:0] refDivide(input logic [23:0] n, input logic [23:0] d,
		input logic [4:0] p, input logic signed [8:0] ne, input logic signed [8:0] de);
		int          pc;
		int          ev;
		logic [63:0] m;
		logic [63:0] r;
		logic [63:0] cand;
		logic [23:0] mant;
		pc = clampPrec(p);
		m = ({40'd0, n} << pc) / {40'd0, d};
		r = (({40'd0, n} << (pc + 1)) / {40'd0, d}) & 64'd1;
		cand = m + r;
		if (cand >= (64'd1 << (pc + 1)))
			cand = m;                  // Rounding up would overflow.
		mant = cand << (23 - pc);
		ev = ne - de + 127;
		return {ev[9:0], mant};
	endfunction

	task automatic reportFail(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Stopping at the first error.");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			reportFail($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
	endtask

	// Results, latency and the Ready level are all checked at the falling edge.
	always @(negedge Clk_CI) begin
		if (Rst_RBI === 1'b1) begin
			if (doneLast)
				checkValue("Done_SO", Done_SO, 1'b0);  // Pulse is one cycle.
			if (!busy)
				checkValue("Done_SO", Done_SO, 1'b0);
			if (Done_SO) begin
				checkValue("Done_SO latency", cycleCnt - startEdge, expLatQ.pop_front());
				checkValue("Ready_SO", Ready_SO, 1'b1);
				checkValue("MantResult_DO", MantResult_DO, expMantQ.pop_front());
				checkValue("ExpResult_DO", ExpResult_DO, expExpQ.pop_front());
				checked = checked + 1;
				busy = 1'b0;
			end else if (busy) begin
				checkValue("Ready_SO", Ready_SO, 1'b0);
			end else begin
				checkValue("Ready_SO", Ready_SO, 1'b1);
			end
			if (Start_SI && !busy) begin
				startEdge = cycleCnt + 1;  // Accepted at the next rising edge.
				busy = 1'b1;
			end
			doneLast = Done_SO;
		end
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	function automatic logic [23:0] randMant();
		logic [31:0] r;
		r = $urandom;
		return {1'b1, r[22:0]};
	endfunction

	function automatic logic [8:0] randExp();
		logic [31:0] r;
		r = $urandom;
		return r[8:0];
	endfunction

	task automatic runDivision(input logic [23:0] n, input logic [23:0] d, input logic [4:0] p,
		input logic signed [8:0] ne, input logic signed [8:0] de, input bit pulseBusy);
		logic [33:0] expv;
		expv = refDivide(n, d, p, ne, de);
		@(posedge Clk_CI);
		expMantQ.push_back(expv[23:0]);
		expExpQ.push_back(expv[33:24]);
		expLatQ.push_back((clampPrec(p) - 8) / 4 + 3);
		issued = issued + 1;
		NumMant_DI   <= n;
		DenMant_DI   <= d;
		Precision_SI <= p;
		NumExp_DI    <= ne;
		DenExp_DI    <= de;
		Start_SI     <= 1'b1;
		@(posedge Clk_CI);
		Start_SI <= 1'b0;
		if (pulseBusy) begin
			@(posedge Clk_CI);
			Start_SI     <= 1'b1;      // Must be ignored while busy.
			Precision_SI <= ~p;
			@(posedge Clk_CI);
			Start_SI     <= 1'b0;
			Precision_SI <= p;
		end
		wait (checked == issued);
	endtask

	initial begin
		logic [31:0] seedDummy;
		logic [23:0] m;
		seedDummy = $urandom(11);
		Rst_RBI      = 1'b0;
		Start_SI     = 1'b0;
		Precision_SI = '0;
		NumMant_DI   = '0;
		DenMant_DI   = '0;
		NumExp_DI    = '0;
		DenExp_DI    = '0;
		repeat (4) @(posedge Clk_CI);
		Rst_RBI <= 1'b1;
		@(negedge Clk_CI);
		checkValue("Ready_SO", Ready_SO, 1'b1);
		checkValue("Done_SO", Done_SO, 1'b0);

		m = randMant();
		runDivision(m, m, 5'd23, randExp(), randExp(), 1'b0);   // Equal mantissas.
		runDivision(24'hFFFFFF, 24'h800000, 5'd23, randExp(), randExp(), 1'b0);
		for (int i = 0; i < NumRand; i++)
			runDivision(randMant(), randMant(), 5'd23, randExp(), randExp(), 1'b0);

		// Every precision group, then the clamped values.
		for (int p = 8; p <= 23; p++)
			for (int i = 0; i < NumPerPrec; i++)
				runDivision(randMant(), randMant(), p[4:0], randExp(), randExp(), 1'b0);
		foreach (outPrec[k])
			for (int i = 0; i < NumPerPrec; i++)
				runDivision(randMant(), randMant(), outPrec[k][4:0], randExp(), randExp(), 1'b0);

		// Exponent extremes, some wrap below zero.
		runDivision(randMant(), randMant(), 5'd23, -9'sd256, 9'sd255, 1'b0);
		runDivision(randMant(), randMant(), 5'd12, 9'sd255, -9'sd256, 1'b0);
		runDivision(randMant(), randMant(), 5'd8, 9'sd0, 9'sd127, 1'b0);
		runDivision(randMant(), randMant(), 5'd17, 9'sd0, 9'sd128, 1'b0);
		for (int i = 0; i < NumExpRand; i++)
			runDivision(randMant(), randMant(), 5'd23, randExp(), randExp(), 1'b0);

		for (int i = 0; i < NumIgnore; i++)
			runDivision(randMant(), randMant(), 5'(8 + 2 * i), randExp(), randExp(), 1'b1);

		@(posedge Clk_CI);
		if (checked != NumTests)
			reportFail("Not every division reported a result.");
		else begin
			$display("Regression passed");
			$finish;
		end
	end

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------

	initial begin
		#(WatchdogCycles * ClkPeriod);
		reportFail("Timeout, Done_SO never came before the time limit ran out.");
	end

endmodule

`default_nettype wire

// File: build.f
verilog/divPkg.sv
verilog/divFsm.sv
verilog/divIterCounter.sv
verilog/divRemainderPath.sv
verilog/divResultAssembly.sv
verilog/divTop.sv
tests/divTb.sv
